// ==== Makefile ====
# Verilator build and run for the arcade I/O shell testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_arcade_io
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

SRCS := $(filter-out +%,$(shell cat build.f))
HDRS := $(wildcard include/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): build.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f build.f

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+include
logic/arcade_pkg.sv
logic/key_decoder.sv
logic/control_mapper.sv
logic/video_output.sv
logic/audio_dac.sv
logic/arcade_io_top.sv
tests/tb_arcade_io.sv

// ==== include/arcade_params.svh ====
// Widths, keyboard scancodes and pixel divider ratio for the arcade I/O shell
// Included by the package, the RTL blocks and the testbench
`ifndef ARCADE_PARAMS_SVH
`define ARCADE_PARAMS_SVH

`define ARCADE_KEY_W   8    // Scancode width
`define ARCADE_COLOR_W 6    // Bits per VGA colour channel
`define ARCADE_PIX_DIV 4    // System clocks per pixel enable

// PS/2 set 2 scancodes of the mapped keys
`define KEY_UP     8'h75    // Cursor up
`define KEY_DOWN   8'h72    // Cursor down
`define KEY_LEFT   8'h6B    // Cursor left
`define KEY_RIGHT  8'h74    // Cursor right
`define KEY_COIN   8'h76    // ESC
`define KEY_START1 8'h05    // F1
`define KEY_START2 8'h06    // F2
`define KEY_FIRE1  8'h29    // Space
`define KEY_FIRE2  8'h11    // Alt

`endif

// ==== logic/arcade_io_top.sv ====
// Control and output shell around an arcade game core
// Keyboard and joysticks to game input bytes, pixel enable, VGA and audio
`timescale 1ns/10ps
`default_nettype none

module arcade_io_top (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	// Keyboard events
	input  logic                  key_strobe,
	input  arcade_pkg::scancode_t key_code,
	input  logic                  key_pressed,
	input  arcade_pkg::joy_t      joy0,
	input  arcade_pkg::joy_t      joy1,
	input  logic                  rotate,
	// Game video
	input  arcade_pkg::chan3_t    red,
	input  arcade_pkg::chan3_t    green,
	input  arcade_pkg::chan2_t    blue,
	input  logic                  hsync,
	input  logic                  vsync,
	input  logic                  hblank,
	input  logic                  vblank,
	input  arcade_pkg::sample_t   sample,
	// To the game core
	output arcade_pkg::game_in_t  in0,
	output arcade_pkg::game_in_t  in1,
	output logic                  ce_pix,
	// Board pins
	output arcade_pkg::vga_chan_t vga_r,
	output arcade_pkg::vga_chan_t vga_g,
	output arcade_pkg::vga_chan_t vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  audio_l,
	output logic                  audio_r
);

	arcade_pkg::key_flags_t keys;

	// ============================================================
	// Controls
	// ============================================================
	key_decoder key_decoder_inst (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.keys        (keys)
	);

	control_mapper control_mapper_inst (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.keys    (keys),
		.joy0    (joy0),
		.joy1    (joy1),
		.rotate  (rotate),
		.in0     (in0),
		.in1     (in1)
	);

	// ============================================================
	// Video and audio
	// ============================================================
	video_output video_output_inst (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.red     (red),
		.green   (green),
		.blue    (blue),
		.hsync   (hsync),
		.vsync   (vsync),
		.hblank  (hblank),
		.vblank  (vblank),
		.ce_pix  (ce_pix),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	audio_dac audio_dac_inst (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.sample  (sample),
		.audio   (audio_l)
	);

	assign audio_r = audio_l;  // Mono on both pins

endmodule

`default_nettype wire

// ==== logic/arcade_pkg.sv ====
// Vector types shared by the arcade I/O shell and its testbench
// Referenced by scoped names, arcade_pkg::name
`default_nettype none

`include "arcade_params.svh"

package arcade_pkg;

	typedef logic [`ARCADE_KEY_W-1:0] scancode_t;    // Keyboard scancode
	typedef logic [7:0] joy_t;                       // Bits 3..0 up/down/left/right
	typedef logic [7:0] game_in_t;                   // Active low input byte
	typedef logic [7:0] sample_t;                    // Unsigned audio sample

	// Game colour channels, 3-3-2 RGB
	typedef logic [2:0] chan3_t;
	typedef logic [1:0] chan2_t;
	typedef logic [`ARCADE_COLOR_W-1:0] vga_chan_t;  // Monitor side channel

	// One flag per mapped key, bit 0 is up, bit 8 is fire 2
	typedef logic [8:0] key_flags_t;

endpackage

`default_nettype wire

// ==== logic/audio_dac.sv ====
// First order delta-sigma converter, 8-bit sample to a one bit stream
// Ones density of the output equals sample/256
`timescale 1ns/10ps
`default_nettype none

module audio_dac (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  arcade_pkg::sample_t sample,
	output logic                audio
);

	localparam int SAMPLE_W = $bits(arcade_pkg::sample_t);

	logic [SAMPLE_W:0] acc_q;  // Carry in the top bit

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc_q <= '0;
		end else begin
			// Residue plus new sample, old carry dropped
			acc_q <= {1'b0, acc_q[SAMPLE_W-1:0]} + {1'b0, sample};
		end
	end

	// Registered carry is the bitstream
	assign audio = acc_q[SAMPLE_W];

endmodule

`default_nettype wire

// ==== logic/control_mapper.sv ====
// Merges key flags with both joysticks, rotates the directions for an
// upright cabinet on its side and registers the game's active low bytes
`timescale 1ns/10ps
`default_nettype none

module control_mapper (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  arcade_pkg::key_flags_t keys,
	input  arcade_pkg::joy_t       joy0,
	input  arcade_pkg::joy_t       joy1,
	input  logic                   rotate,   // Low selects rotated controls
	output arcade_pkg::game_in_t   in0,
	output arcade_pkg::game_in_t   in1
);

	logic up, down, left, right;          // Merged, before rotation
	logic m_up, m_down, m_left, m_right;  // As seen by the game
	logic m_fire;
	arcade_pkg::game_in_t in0_q;
	arcade_pkg::game_in_t in1_q;

	// ============================================================
	// Merge and rotate
	// ============================================================
	assign up     = keys[0] | joy0[3] | joy1[3];
	assign down   = keys[1] | joy0[2] | joy1[2];
	assign left   = keys[2] | joy0[1] | joy1[1];
	assign right  = keys[3] | joy0[0] | joy1[0];
	assign m_fire = keys[7] | joy0[4] | joy1[4];

	always_comb begin
		if (!rotate) begin
			m_up    = left;
			m_down  = right;
			m_left  = down;
			m_right = up;
		end else begin
			m_up    = up;
			m_down  = down;
			m_left  = left;
			m_right = right;
		end
	end

	// ============================================================
	// Input byte registers
	// ============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			in0_q <= '1;  // Nothing pressed
			in1_q <= '1;
		end else begin
			in0_q <= ~{2'b00, keys[4], m_fire, m_down, m_right, m_left, m_up};
			in1_q <= ~{1'b0, keys[6], keys[5], 5'b00000};  // Start 2, start 1
		end
	end

	assign in0 = in0_q;
	assign in1 = in1_q;

endmodule

`default_nettype wire

// ==== logic/key_decoder.sv ====
// Tracks the held state of each mapped key from keyboard strobe events
// A press sets and a release clears only the flag of its own key
`timescale 1ns/10ps
`default_nettype none

`include "arcade_params.svh"

module key_decoder (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   key_strobe,   // Single cycle event
	input  arcade_pkg::scancode_t  key_code,
	input  logic                   key_pressed,  // 1 press, 0 release
	output arcade_pkg::key_flags_t keys
);

	arcade_pkg::key_flags_t flags_q;

	// ============================================================
	// Flag register
	// ============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			flags_q <= '0;
		end else if (key_strobe) begin
			case (key_code)
				`KEY_UP:     flags_q[0] <= key_pressed;
				`KEY_DOWN:   flags_q[1] <= key_pressed;
				`KEY_LEFT:   flags_q[2] <= key_pressed;
				`KEY_RIGHT:  flags_q[3] <= key_pressed;
				`KEY_COIN:   flags_q[4] <= key_pressed;
				`KEY_START1: flags_q[5] <= key_pressed;
				`KEY_START2: flags_q[6] <= key_pressed;
				`KEY_FIRE1:  flags_q[7] <= key_pressed;
				`KEY_FIRE2:  flags_q[8] <= key_pressed;
				default: begin
					flags_q <= flags_q;  // Unmapped code, keep all flags
				end
			endcase
		end
	end

	// Several flags may be set together, there is no exclusion
	// between keys, so diagonals and fire while moving both work

	assign keys = flags_q;

endmodule

`default_nettype wire

// ==== logic/video_output.sv ====
// Pixel clock enable for the game core and the registered VGA stage
// Blanks the 3-3-2 colour, widens it to 6 bits per channel and flips sync
`timescale 1ns/10ps
`default_nettype none

`include "arcade_params.svh"

module video_output (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  arcade_pkg::chan3_t    red,
	input  arcade_pkg::chan3_t    green,
	input  arcade_pkg::chan2_t    blue,
	input  logic                  hsync,
	input  logic                  vsync,
	input  logic                  hblank,
	input  logic                  vblank,
	output logic                  ce_pix,
	output arcade_pkg::vga_chan_t vga_r,
	output arcade_pkg::vga_chan_t vga_g,
	output arcade_pkg::vga_chan_t vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs
);

	localparam int PIX_DIV = `ARCADE_PIX_DIV;
	localparam int DIV_W   = $clog2(PIX_DIV);

	logic [DIV_W-1:0] div_q;
	logic             blank;

	// ============================================================
	// Pixel enable divider
	// ============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div_q  <= '0;
			ce_pix <= 1'b0;
		end else begin
			div_q  <= (div_q == DIV_W'(PIX_DIV - 1)) ? '0 : div_q + 1'b1;
			ce_pix <= (div_q == '0);  // One pulse per wrap
		end
	end

	assign blank = hblank | vblank;

	// Registered display stage, bits repeated to fill the channel
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else begin
			vga_r  <= blank ? '0 : {red, red};
			vga_g  <= blank ? '0 : {green, green};
			vga_b  <= blank ? '0 : {blue, blue, blue};
			vga_hs <= ~hsync;  // Game sync is active high
			vga_vs <= ~vsync;
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_arcade_io.sv ====
// Testbench for the arcade I/O shell, random stimulus against reference functions
// A model process builds expected outputs and a comparing process checks every clock
`timescale 1ns/10ps
`default_nettype none

`include "arcade_params.svh"

module tb_arcade_io;

	logic                  clk_sys = 1'b0;
	logic                  arst_n;
	logic                  key_strobe;
	logic                  key_pressed;
	logic                  rotate;
	arcade_pkg::scancode_t key_code;
	arcade_pkg::joy_t      joy0;
	arcade_pkg::joy_t      joy1;
	arcade_pkg::chan3_t    red;
	arcade_pkg::chan3_t    green;
	arcade_pkg::chan2_t    blue;
	logic                  hsync;
	logic                  vsync;
	logic                  hblank;
	logic                  vblank;
	arcade_pkg::sample_t   sample;
	arcade_pkg::game_in_t  in0;
	arcade_pkg::game_in_t  in1;
	arcade_pkg::vga_chan_t vga_r;
	arcade_pkg::vga_chan_t vga_g;
	arcade_pkg::vga_chan_t vga_b;
	logic                  ce_pix;
	logic                  vga_hs;
	logic                  vga_vs;
	logic                  audio_l;
	logic                  audio_r;

	arcade_pkg::key_flags_t model_keys;  // Expected held keys
	logic [15:0]            exp_in;      // {in1, in0}
	logic [17:0]            exp_rgb;
	logic                   exp_hs;
	logic                   exp_vs;

	integer seed = 32'h3b45_5418;
	integer cmp_checks = 0;
	integer cmp_errors = 0;
	integer flow_checks = 0;
	integer flow_errors = 0;

	arcade_pkg::scancode_t mapped [9] = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT,
		`KEY_COIN, `KEY_START1, `KEY_START2, `KEY_FIRE1, `KEY_FIRE2};
	arcade_pkg::sample_t levels [4] = '{8'd0, 8'd1, 8'd128, 8'd255};

	always #20 clk_sys = ~clk_sys;  // 40 ns period

	arcade_io_top arcade_io_top_inst (.*);

	// ============================================================
	// Reference functions
	// ============================================================
	// One key event, flag order follows the scancode list
	function automatic arcade_pkg::key_flags_t apply_key(input arcade_pkg::key_flags_t flags,
			input arcade_pkg::scancode_t code, input logic pressed);
		arcade_pkg::key_flags_t upd;
		upd = flags;
		case (code)
			`KEY_UP:     upd[0] = pressed;
			`KEY_DOWN:   upd[1] = pressed;
			`KEY_LEFT:   upd[2] = pressed;
			`KEY_RIGHT:  upd[3] = pressed;
			`KEY_COIN:   upd[4] = pressed;
			`KEY_START1: upd[5] = pressed;
			`KEY_START2: upd[6] = pressed;
			`KEY_FIRE1:  upd[7] = pressed;
			`KEY_FIRE2:  upd[8] = pressed;
			default: ;
		endcase
		return upd;
	endfunction

	function automatic logic [15:0] ref_inputs(input arcade_pkg::key_flags_t flags,
			input arcade_pkg::joy_t j0, input arcade_pkg::joy_t j1, input logic rot);
		logic       u, d, l, r, f;
		logic [3:0] dir;  // Up, down, left, right as the game sees them
		u = flags[0] | j0[3] | j1[3];
		d = flags[1] | j0[2] | j1[2];
		l = flags[2] | j0[1] | j1[1];
		r = flags[3] | j0[0] | j1[0];
		f = flags[7] | j0[4] | j1[4];
		dir = rot ? {u, d, l, r} : {l, r, d, u};  // Side cabinet when low
		return {~{1'b0, flags[6], flags[5], 5'b00000},
			~{2'b00, flags[4], f, dir[2], dir[0], dir[1], dir[3]}};
	endfunction

	function automatic logic [17:0] ref_video(input arcade_pkg::chan3_t r,
			input arcade_pkg::chan3_t g, input arcade_pkg::chan2_t b, input logic blank);
		logic [17:0] rgb;
		if (blank)
			rgb = '0;
		else
			rgb = {r, r, g, g, b, b, b};
		return rgb;
	endfunction

	// Expected registered outputs, built from the inputs seen at each edge
	always @(posedge clk_sys) begin
		if (!arst_n) begin
			model_keys <= '0;
			exp_in     <= '1;
			exp_rgb    <= '0;
			exp_hs     <= 1'b1;
			exp_vs     <= 1'b1;
		end else begin
			exp_in  <= ref_inputs(model_keys, joy0, joy1, rotate);
			exp_rgb <= ref_video(red, green, blue, hblank | vblank);
			exp_hs  <= ~hsync;
			exp_vs  <= ~vsync;
			if (key_strobe)
				model_keys <= apply_key(model_keys, key_code, key_pressed);
		end
	end

	// ============================================================
	// Comparing process, outputs are stable at the falling edge
	// ============================================================
	always @(negedge clk_sys) begin
		cmp_checks = cmp_checks + 1;
		assert ({in1, in0} === exp_in) else begin
			cmp_errors++;
			$display("[FAIL] %0t: in1/in0 %h, expected %h", $time, {in1, in0}, exp_in);
		end
		assert ({vga_r, vga_g, vga_b} === exp_rgb) else begin
			cmp_errors++;
			$display("[FAIL] %0t: rgb %h, expected %h", $time, {vga_r, vga_g, vga_b}, exp_rgb);
		end
		assert ({vga_hs, vga_vs} === {exp_hs, exp_vs}) else begin
			cmp_errors++;
			$display("[FAIL] %0t: hs/vs %b%b, expected %b%b", $time, vga_hs, vga_vs,
				exp_hs, exp_vs);
		end
		assert (audio_r === audio_l) else begin
			cmp_errors++;
			$display("[FAIL] %0t: audio_r %b differs from audio_l %b", $time, audio_r, audio_l);
		end
		if (!arst_n) begin
			assert (ce_pix === 1'b0 && audio_l === 1'b0) else begin
				cmp_errors++;
				$display("[FAIL] %0t: ce_pix %b audio %b in reset", $time, ce_pix, audio_l);
			end
		end
	end

	task automatic step;  // Inputs change just after the rising edge
		@(posedge clk_sys);
		#2;
	endtask

	// ============================================================
	// Stimulus
	// ============================================================
	initial begin
		integer      i;
		integer      n;
		integer      last;
		integer      pulses;
		integer      ones;
		integer      pick;
		logic [31:0] rnd;
		logic        timed_out;
		key_strobe = 1'b0;
		key_code = '0;
		key_pressed = 1'b0;
		joy0 = '0;
		joy1 = '0;
		rotate = 1'b1;
		red = '0;
		green = '0;
		blue = '0;
		hsync = 1'b0;
		vsync = 1'b0;
		hblank = 1'b0;
		vblank = 1'b0;
		sample = '0;
		arst_n = 1'b0;
		repeat (5) @(posedge clk_sys);
		#2 arst_n = 1'b1;

		// First pixel enable, bounded wait
		n = 0;
		while (ce_pix !== 1'b1 && n < 4 * `ARCADE_PIX_DIV) begin
			@(negedge clk_sys);
			n++;
		end
		timed_out = (ce_pix !== 1'b1);
		if (timed_out) begin
			flow_errors++;
			$display("Timeout: no ce_pix pulse seen after reset");
		end else begin
			last = 0;
			pulses = 0;
			for (i = 1; i <= 400; i++) begin
				@(negedge clk_sys);
				if (ce_pix) begin
					flow_checks++;
					pulses++;
					assert (i - last == `ARCADE_PIX_DIV) else begin
						flow_errors++;
						$display("[FAIL] %0t: ce_pix gap %0d cycles", $time, i - last);
					end
					last = i;
				end
			end
			flow_checks++;
			assert (pulses == 400 / `ARCADE_PIX_DIV) else begin
				flow_errors++;
				$display("[FAIL] %0t: %0d ce_pix pulses in 400 cycles", $time, pulses);
			end

			// Key events, mapped and unmapped codes
			for (i = 0; i < 80; i++) begin
				step();
				rnd = $random(seed);
				pick = rnd % 12;
				key_strobe = 1'b1;
				key_code = (pick < 9) ? mapped[pick] : rnd[15:8];
				key_pressed = rnd[16];
				rotate = rnd[17];
				step();
				key_strobe = 1'b0;
				repeat (2) step();
			end
			for (i = 0; i < 9; i++) begin  // Release all before joystick test
				step();
				key_strobe = 1'b1;
				key_code = mapped[i];
				key_pressed = 1'b0;
			end
			step();
			key_strobe = 1'b0;

			// Joysticks and rotation
			for (i = 0; i < 100; i++) begin
				step();
				rnd = $random(seed);
				joy0 = rnd[7:0];
				joy1 = rnd[15:8];
				rotate = rnd[16];
			end

			// Colour, sync and blanking, about one in four blanked per flag
			for (i = 0; i < 100; i++) begin
				step();
				rnd = $random(seed);
				red = rnd[2:0];
				green = rnd[5:3];
				blue = rnd[7:6];
				hsync = rnd[8];
				vsync = rnd[9];
				hblank = (rnd[11:10] == 2'b00);
				vblank = (rnd[13:12] == 2'b00);
			end

			// Audio density over one window after a settle window
			for (i = 0; i < 4; i++) begin
				step();
				sample = levels[i];
				repeat (256) @(negedge clk_sys);
				ones = 0;
				repeat (256) begin
					@(negedge clk_sys);
					if (audio_l)
						ones++;
				end
				flow_checks++;
				assert (ones == 32'(levels[i])) else begin
					flow_errors++;
					$display("[FAIL] %0t: %0d ones for sample %0d", $time, ones, levels[i]);
				end
			end
		end

		$display("Checks: %0d, errors: %0d", cmp_checks + flow_checks, cmp_errors + flow_errors);
		if (cmp_errors + flow_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
